// ==== vlog.f ====
common/dcache_pkg.sv
dcache/miss_tracker.sv
dcache/dcache.sv
source/tagged_memory.sv
source/dcache_top.sv
tests/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass line shows up
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f vlog.f --top-module dcache_tb -o dcache_sim \
    && ./obj_dir/dcache_sim | tee /dev/stderr \
        | grep -F "Simulation completed successfully" > /dev/null \
    && echo "dcache run passed" \
    || { echo "dcache run did not pass"; exit 1; }

// ==== tests/dcache_tb.sv ====
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int TIMEOUT_CYCLES = 40;

    logic       clk;
    logic       reset;
    proc_req_t  proc_req;
    apb_req_t   apb_req;
    load_resp_t load_resp;
    fill_resp_t fill_resp;
    apb_resp_t  apb_resp;

    logic [63:0] mirror [MEM_DEPTH];   // copy of every accepted APB write
    logic [31:0] line_addr [16];       // lines filled by the preload test

    dcache_top dcache_top_inst (
        .clk       (clk),
        .reset     (reset),
        .proc_req  (proc_req),
        .apb_req   (apb_req),
        .load_resp (load_resp),
        .fill_resp (fill_resp),
        .apb_resp  (apb_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // doubleword number inside the backing store
    function automatic logic [MEM_INDEX_BITS-1:0] dw_of(input logic [31:0] addr);
        return addr[OFFSET_BITS +: MEM_INDEX_BITS];
    endfunction

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic timed_out(input string what);
        $display("gave up waiting for %s after %0d cycles", what, TIMEOUT_CYCLES);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_nonzero(input string name, input logic [63:0] actual);
        assert (actual != '0) else begin
            $display("CHECK FAILED time=%0t %s expected=nonzero actual=%h", $time, name, actual);
            stop_run();
        end
    endtask

    // setup phase then access phase and returns at the start of the access cycle
    task automatic apb_start(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk);
        apb_req.penable = 1'b1;
    endtask

    task automatic apb_finish(input logic expect_err);
        @(negedge clk);   // access cycle is over with zero wait states
        check_value("apb_resp.pready", 64'd1, 64'(apb_resp.pready));
        check_value("apb_resp.pslverr", 64'(expect_err), 64'(apb_resp.pslverr));
        if (!expect_err) begin
            // paddr bit 2 picks the upper word
            mirror[dw_of(apb_req.paddr)][{apb_req.paddr[2], 5'd0} +: 32] = apb_req.pwdata;
        end
        apb_req = '0;
    endtask

    task automatic write_dword(input logic [31:0] addr, input logic [63:0] data);
        apb_start({addr[31:3], 3'd0}, data[31:0]);
        apb_finish(1'b0);
        apb_start({addr[31:3], 3'd4}, data[63:32]);
        apb_finish(1'b0);
    endtask

    // one request cycle whose answer is registered at the edge in between
    task automatic send_load(input logic [31:0] addr);
        @(negedge clk);
        proc_req = '{valid: 1'b1, addr: addr};
        @(negedge clk);
        proc_req.valid = 1'b0;
    endtask

    task automatic check_idle();
        check_value("load_resp.hit", 64'd0, 64'(load_resp.hit));
        check_value("load_resp.data_response", 64'd0, 64'(load_resp.data_response));
    endtask

    task automatic check_hit(input logic [31:0] addr);
        check_value("load_resp.hit", 64'd1, 64'(load_resp.hit));
        check_value("load_resp.hit_data", mirror[dw_of(addr)], load_resp.hit_data);
        check_value("load_resp.data_response", 64'd0, 64'(load_resp.data_response));
    endtask

    task automatic check_accepted(output mem_tag_t tag);
        tag = load_resp.data_response;
        check_value("load_resp.hit", 64'd0, 64'(load_resp.hit));
        check_nonzero("load_resp.data_response", 64'(tag));
    endtask

    // fill is due MEM_LATENCY cycles after the data_response
    task automatic wait_fill(input mem_tag_t tag, input logic [31:0] addr);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) timed_out("a fill");
        end while (fill_resp.data_tag == '0);
        check_value("fill_resp.data_tag", 64'(tag), 64'(fill_resp.data_tag));
        check_value("fill_resp.fill_data", mirror[dw_of(addr)], fill_resp.fill_data);
        check_value("fill latency", 64'(MEM_LATENCY), 64'(cycles));
    endtask

    task automatic miss_and_fill(input logic [31:0] addr);
        mem_tag_t tag;
        send_load(addr);
        check_accepted(tag);
        wait_fill(tag, addr);
    endtask

    task automatic reset_state();
        logic [31:0] addr;
        check_idle();
        check_value("fill_resp.data_tag", 64'd0, 64'(fill_resp.data_tag));
        addr = {19'd0, 5'd2, 5'd31, 3'd0};   // index 31 which no other test uses
        write_dword(addr, {$urandom, $urandom});
        miss_and_fill(addr);
    endtask

    task automatic apb_preload_and_miss_fill();
        for (int i = 0; i < 16; i++) begin
            line_addr[i] = {19'd0, 5'($urandom), 5'(i), 3'd0};   // line i gets index i
            write_dword(line_addr[i], {$urandom, $urandom});
        end
        // beyond MEM_DEPTH with the low bits of line 0
        apb_start(32'h0001_0000 | line_addr[0], $urandom);
        apb_finish(1'b1);
        for (int i = 0; i < 16; i++) begin
            miss_and_fill(line_addr[i]);
        end
    endtask

    task automatic hit_after_fill();
        logic [31:0] addr;
        for (int i = 0; i < 16; i++) begin
            send_load(line_addr[i]);
            check_hit(line_addr[i]);
            addr = line_addr[i] + 32'($urandom % 7 + 1);   // other byte of the same line
            send_load(addr);
            check_hit(addr);
        end
    endtask

    task automatic non_blocking_misses();
        logic [31:0]             seq_addr [6];
        logic [31:0]             tag_addr [NUM_MEM_TAGS];   // address behind each live tag
        logic [NUM_MEM_TAGS-1:0] pending;
        mem_tag_t                tag;
        int                      next;
        int                      fills;
        int                      cycles;
        for (int i = 0; i < 6; i++) begin
            seq_addr[i] = {19'd0, 5'($urandom), 5'(16 + i), 3'd0};
            write_dword(seq_addr[i], {$urandom, $urandom});
        end
        seq_addr[2] = line_addr[3];   // slot 2 is a hit between the misses
        pending = '0;
        next    = 0;
        fills   = 0;
        cycles  = 0;
        @(negedge clk);
        proc_req = '{valid: 1'b1, addr: seq_addr[0]};
        while (fills < 5) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) timed_out("five overlapping fills");
            if (next == 2) begin
                check_hit(seq_addr[next]);   // one cycle even with misses out
                next++;
            end else if (next < 6) begin
                tag = load_resp.data_response;
                check_value("load_resp.hit", 64'd0, 64'(load_resp.hit));
                if (tag != '0) begin
                    check_value("busy flag of load_resp.data_response", 64'd0, 64'(pending[tag]));
                    pending[tag]  = 1'b1;
                    tag_addr[tag] = seq_addr[next];
                    next++;
                end   // a zero answer keeps the same request up
            end
            tag = fill_resp.data_tag;
            if (tag != '0) begin
                check_value("busy flag of fill_resp.data_tag", 64'd1, 64'(pending[tag]));
                check_value("fill_resp.fill_data", mirror[dw_of(tag_addr[tag])],
                            fill_resp.fill_data);
                pending[tag] = 1'b0;
                fills++;
            end
            if (next < 6) proc_req.addr = seq_addr[next];
            else proc_req.valid = 1'b0;
        end
    endtask

    task automatic in_flight_and_conflict();
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        mem_tag_t    tag;
        int          cycles;
        addr_a = {19'd0, 5'd3, 5'd24, 3'd0};
        addr_b = {19'd0, 5'd9, 5'd24, 3'd0};   // same index with another tag
        write_dword(addr_a, {$urandom, $urandom});
        write_dword(addr_b, {$urandom, $urandom});
        @(negedge clk);
        proc_req = '{valid: 1'b1, addr: addr_a};
        @(negedge clk);
        check_accepted(tag);
        cycles = 0;
        do begin   // request held and every retry until the fill is refused
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) timed_out("the fill of the pending line");
            check_idle();
        end while (fill_resp.data_tag == '0);
        check_value("fill_resp.data_tag", 64'(tag), 64'(fill_resp.data_tag));
        check_value("fill_resp.fill_data", mirror[dw_of(addr_a)], fill_resp.fill_data);
        @(negedge clk);   // retry in the cycle after the fill
        proc_req.valid = 1'b0;
        check_hit(addr_a);
        miss_and_fill(addr_b);   // evicts addr_a
        send_load(addr_b);
        check_hit(addr_b);
        miss_and_fill(addr_a);
    endtask

    task automatic apb_backpressure();
        logic [31:0] addr_c;
        mem_tag_t    tag;
        addr_c = {19'd0, 5'd6, 5'd28, 3'd0};
        write_dword(addr_c, {$urandom, $urandom});
        apb_start({19'd0, 5'd7, 5'd29, 3'd4}, $urandom);
        proc_req = '{valid: 1'b1, addr: addr_c};   // load during the access phase
        apb_finish(1'b0);
        check_idle();
        @(negedge clk);   // same load with the bus free now
        proc_req.valid = 1'b0;
        check_accepted(tag);
        wait_fill(tag, addr_c);
    endtask

    initial begin
        void'($urandom(40031));
        reset    = 1'b1;
        proc_req = '0;
        apb_req  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_state();
        apb_preload_and_miss_fill();
        hit_after_fill();
        non_blocking_misses();
        in_flight_and_conflict();
        apb_backpressure();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`default_nettype none

// cache, miss tracker and backing memory
module dcache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::proc_req_t  proc_req,
    input  dcache_pkg::apb_req_t   apb_req,
    output dcache_pkg::load_resp_t load_resp,
    output dcache_pkg::fill_resp_t fill_resp,
    output dcache_pkg::apb_resp_t  apb_resp
);
    import dcache_pkg::*;

    mem_req_t                mem_req;
    mem_resp_t               mem_resp;
    logic                    in_flight;
    cache_addr_t             fill_addr;
    logic                    record_valid;
    mem_tag_t                record_tag;
    cache_addr_t             record_addr;
    logic [INDEX_BITS-1:0]   lookup_index;

    dcache dcache_inst (
        .clk          (clk),
        .reset        (reset),
        .proc_req     (proc_req),
        .mem_resp     (mem_resp),
        .in_flight    (in_flight),
        .fill_addr    (fill_addr),
        .load_resp    (load_resp),
        .fill_resp    (fill_resp),
        .mem_req      (mem_req),
        .record_valid (record_valid),
        .record_tag   (record_tag),
        .record_addr  (record_addr),
        .lookup_index (lookup_index)
    );

    miss_tracker miss_tracker_inst (
        .clk          (clk),
        .reset        (reset),
        .record_valid (record_valid),
        .record_tag   (record_tag),
        .record_addr  (record_addr),
        .lookup_index (lookup_index),
        .return_tag   (mem_resp.tag),    // freed on the fill cycle
        .in_flight    (in_flight),
        .fill_addr    (fill_addr)
    );

    tagged_memory tagged_memory_inst (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .apb_req  (apb_req),
        .mem_resp (mem_resp),
        .apb_resp (apb_resp)
    );

endmodule

`default_nettype wire

// ==== source/tagged_memory.sv ====
`default_nettype none

// backing store with APB writes and tagged loads of fixed latency
module tagged_memory (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::apb_req_t  apb_req,
    output dcache_pkg::mem_resp_t mem_resp,
    output dcache_pkg::apb_resp_t apb_resp
);
    import dcache_pkg::*;

    logic [63:0] mem_array [MEM_DEPTH];

    // APB side
    logic                       apb_access;    // access phase of a transfer
    logic [XLEN-OFFSET_BITS-1:0] apb_dw_addr;   // doubleword address of paddr
    logic                       apb_range_err;
    logic                       apb_write_ok;
    logic [MEM_INDEX_BITS-1:0]  apb_index;

    // tag allocation
    logic [NUM_MEM_TAGS-1:0] tag_busy;   // bit 0 never set
    mem_tag_t                grant_tag;  // lowest free tag or 0 when none
    logic                    accept;

    // return pipeline
    mem_tag_t                  pipe_tag   [MEM_LATENCY];
    logic [MEM_INDEX_BITS-1:0] pipe_index [MEM_LATENCY];
    mem_tag_t                  ret_tag;
    logic [MEM_INDEX_BITS-1:0] ret_index;

    assign apb_access    = apb_req.psel && apb_req.penable;
    assign apb_dw_addr   = apb_req.paddr[XLEN-1:OFFSET_BITS];
    assign apb_range_err = (apb_dw_addr >= MEM_DEPTH);
    assign apb_write_ok  = apb_access && apb_req.pwrite && !apb_range_err;
    assign apb_index     = apb_dw_addr[MEM_INDEX_BITS-1:0];

    always_comb begin
        apb_resp.pready  = apb_access;   // zero wait states
        // reads are not supported and are flagged like a bad address
        apb_resp.pslverr = apb_access && (!apb_req.pwrite || apb_range_err);
    end

    // half doubleword writes where paddr bit 2 picks the upper word
    always_ff @(posedge clk) begin
        if (apb_write_ok) begin
            if (apb_req.paddr[2]) begin
                mem_array[apb_index][63:32] <= apb_req.pwdata;
            end else begin
                mem_array[apb_index][31:0] <= apb_req.pwdata;
            end
        end
    end

    // priority pick where the lowest index wins
    always_comb begin
        grant_tag = '0;
        for (int i = NUM_MEM_TAGS - 1; i >= 1; i--) begin
            if (!tag_busy[i]) begin
                grant_tag = mem_tag_t'(i);
            end
        end
    end

    // refuse while APB owns the array or all tags are out
    assign accept = (mem_req.command == BUS_LOAD) && !apb_access && (grant_tag != '0);

    assign ret_tag   = pipe_tag[MEM_LATENCY-1];
    assign ret_index = pipe_index[MEM_LATENCY-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_busy <= '0;
            for (int i = 0; i < MEM_LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= accept ? grant_tag : '0;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
            if (ret_tag != '0) begin
                tag_busy[ret_tag] <= 1'b0;   // free again next cycle
            end
            if (accept) begin
                tag_busy[grant_tag] <= 1'b1;
            end
        end
    end

    // index travels with the tag
    always_ff @(posedge clk) begin
        pipe_index[0] <= mem_req.addr[OFFSET_BITS +: MEM_INDEX_BITS];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_index[i] <= pipe_index[i-1];
        end
    end

    always_comb begin
        mem_resp.response = accept ? grant_tag : '0;
        mem_resp.tag      = ret_tag;
        mem_resp.data     = mem_array[ret_index];   // read at exit so late APB writes are seen
    end

endmodule

`default_nettype wire

// ==== dcache/dcache.sv ====
`default_nettype none

// direct mapped read-only cache, one doubleword per line
// misses go out tagged, the tracker remembers where each fill belongs
module dcache (
    input  logic                              clk,
    input  logic                              reset,
    input  dcache_pkg::proc_req_t             proc_req,
    input  dcache_pkg::mem_resp_t             mem_resp,
    input  logic                              in_flight,     // line of proc_req already fetching
    input  dcache_pkg::cache_addr_t           fill_addr,     // address behind mem_resp.tag
    output dcache_pkg::load_resp_t            load_resp,
    output dcache_pkg::fill_resp_t            fill_resp,
    output dcache_pkg::mem_req_t              mem_req,
    output logic                              record_valid,
    output dcache_pkg::mem_tag_t              record_tag,
    output dcache_pkg::cache_addr_t           record_addr,
    output logic [dcache_pkg::INDEX_BITS-1:0] lookup_index
);
    import dcache_pkg::*;

    // line storage
    logic [63:0]          line_data [NUM_LINES];
    logic [TAG_BITS-1:0]  line_tag  [NUM_LINES];
    logic [NUM_LINES-1:0] line_valid;

    cache_addr_t req_addr;     // request address split into fields
    logic        lookup_hit;
    logic        miss_issue;   // send a load this cycle
    logic        fill_valid;   // memory returning a line this cycle

    // output registers
    logic        hit_q;
    logic [63:0] hit_data_q;
    mem_tag_t    data_response_q;
    mem_tag_t    data_tag_q;
    logic [63:0] fill_data_q;

    assign req_addr     = proc_req.addr;
    assign lookup_index = req_addr.index;   // tracker checks this index for a pending fill

    // tag compare against the indexed line
    assign lookup_hit = proc_req.valid
                        && line_valid[req_addr.index]
                        && (line_tag[req_addr.index] == req_addr.tag);

    // a miss to a line already being fetched is not issued again
    assign miss_issue = proc_req.valid && !lookup_hit && !in_flight;

    assign fill_valid = (mem_resp.tag != '0);

    always_comb begin
        mem_req.command = miss_issue ? BUS_LOAD : BUS_NONE;
        // line aligned, offset bits dropped
        mem_req.addr    = {req_addr.tag, req_addr.index, {OFFSET_BITS{1'b0}}};
    end

    // memory answers in the same cycle, record only what it accepted
    assign record_valid = miss_issue && (mem_resp.response != '0);
    assign record_tag   = mem_resp.response;
    assign record_addr  = req_addr;

    // control state and valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            hit_q           <= 1'b0;
            data_response_q <= '0;
            data_tag_q      <= '0;
            line_valid      <= '0;
        end else begin
            hit_q           <= lookup_hit;                          // one cycle pulse
            data_response_q <= record_valid ? mem_resp.response : '0;
            data_tag_q      <= mem_resp.tag;                        // zero when nothing returns
            if (fill_valid) begin
                line_valid[fill_addr.index] <= 1'b1;
            end
        end
    end

    // payload, read data is qualified by hit_q and data_tag_q
    always_ff @(posedge clk) begin
        hit_data_q  <= line_data[req_addr.index];
        fill_data_q <= mem_resp.data;
        if (fill_valid) begin
            // fill lands at the index recorded for this tag, may evict another address
            line_data[fill_addr.index] <= mem_resp.data;
            line_tag[fill_addr.index]  <= fill_addr.tag;
        end
    end

    always_comb begin
        load_resp.hit           = hit_q;
        load_resp.hit_data      = hit_data_q;
        load_resp.data_response = data_response_q;
        fill_resp.data_tag      = data_tag_q;
        fill_resp.fill_data     = fill_data_q;
    end

endmodule

`default_nettype wire

// ==== dcache/miss_tracker.sv ====
`default_nettype none

// one entry per memory transaction tag and entry 0 stays empty
module miss_tracker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              record_valid,
    input  dcache_pkg::mem_tag_t              record_tag,
    input  dcache_pkg::cache_addr_t           record_addr,
    input  logic [dcache_pkg::INDEX_BITS-1:0] lookup_index,
    input  dcache_pkg::mem_tag_t              return_tag,
    output logic                              in_flight,
    output dcache_pkg::cache_addr_t           fill_addr
);
    import dcache_pkg::*;

    cache_addr_t             entry_addr [NUM_MEM_TAGS];   // missed address per tag
    logic [NUM_MEM_TAGS-1:0] entry_busy;                  // fill still outstanding

    // busy bits
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_busy <= '0;
        end else begin
            if (return_tag != '0) begin
                entry_busy[return_tag] <= 1'b0;   // fill lands and the line is no longer pending
            end
            // the memory never regrants a tag in its return cycle
            if (record_valid) begin
                entry_busy[record_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (record_valid) begin
            entry_addr[record_tag] <= record_addr;
        end
    end

    // any pending fill for the looked up index blocks a second fetch
    always_comb begin
        in_flight = 1'b0;
        for (int i = 1; i < NUM_MEM_TAGS; i++) begin
            if (entry_busy[i] && (entry_addr[i].index == lookup_index)) begin
                in_flight = 1'b1;
            end
        end
    end

    // combinational read of the address behind the returning fill
    assign fill_addr = entry_addr[return_tag];

endmodule

`default_nettype wire

// ==== common/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // address geometry: 32 lines of one doubleword each
    localparam int XLEN        = 32;
    localparam int TAG_BITS    = 24;
    localparam int INDEX_BITS  = 5;
    localparam int OFFSET_BITS = 3;
    localparam int NUM_LINES   = 32;

    // backing memory transaction tags, tag 0 means no transaction
    localparam int MEM_TAG_BITS = 4;
    localparam int NUM_MEM_TAGS = 16;

    localparam int MEM_DEPTH      = 1024;               // doublewords
    localparam int MEM_INDEX_BITS = $clog2(MEM_DEPTH);
    localparam int MEM_LATENCY    = 6;                  // accept to return, in cycles

    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2   // reserved, the cache is read-only
    } bus_command_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
    } proc_req_t;

    typedef struct packed {
        logic        hit;            // hit_data valid this cycle
        logic [63:0] hit_data;
        mem_tag_t    data_response;  // nonzero when a miss went out under this tag
    } load_resp_t;

    typedef struct packed {
        mem_tag_t    data_tag;       // nonzero when fill_data is valid
        logic [63:0] fill_data;
    } fill_resp_t;

    typedef struct packed {
        bus_command_t    command;
        logic [XLEN-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t    response;       // same cycle accept of a load
        logic [63:0] data;
        mem_tag_t    tag;            // returning transaction
    } mem_resp_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [XLEN-1:0] paddr;
        logic [31:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic pready;
        logic pslverr;
    } apb_resp_t;

endpackage

`default_nettype wire
